// File: blast_pkg.sv
package blast_pkg;

   // sizes
   localparam int MEM_ADDR_W  = 14;
   localparam int MEM_DATA_W  = 64;
   localparam int CHAR_W      = 3;
   localparam int BLOCK_WORDS = 6;
   localparam int BLOCK_CHARS = 128;
   localparam int SEED_LEN    = 4;
   localparam int FIFO_DEPTH  = 16;

   // memory map
   localparam logic [MEM_ADDR_W-1:0] MEM_QUERY_ADDR   = 14'd0;
   localparam logic [MEM_ADDR_W-1:0] MEM_SUBJECT_ADDR = 14'd12;
   localparam logic [MEM_ADDR_W-1:0] MEM_HIT_ADDR     = 14'd1024;

   typedef enum logic [2:0] {
      IDLE,
      LOAD_QUERY,
      READ_SUBJECT_HEADER,
      LOAD_SUBJECT,
      WRITE_HITS,
      WRITE_HEADER
   } blast_state_e;

   typedef enum logic [7:0] {
      READ_QUERY   = 8'hAA,
      READ_SUBJECT = 8'hBB
   } app_code_e;

   typedef struct packed {
      logic [MEM_ADDR_W-1:0] addr;
      logic                  read;
      logic                  write;
      logic [MEM_DATA_W-1:0] writedata;
   } mem_req_t;

   typedef struct packed {
      logic              valid;
      logic [CHAR_W-1:0] code;
   } seq_char_t;

   typedef struct packed {
      logic [23:0] subject_id;
      logic [23:0] subject_pos;
      logic [7:0]  query_pos;
      logic [7:0]  match_count;
   } hit_rec_t;

   typedef struct packed {
      logic load_query;
      logic read_header;
      logic load_subject;
      logic write_hits;
      logic write_header;
      logic start_subject;
   } phase_t;

endpackage

// File: blast_ctrl.sv
`timescale 1ns/100ps

module blast_ctrl (
   input  logic                 clk,
   input  logic                 reset,
   input  logic                 app_ready,
   input  blast_pkg::app_code_e app_code,
   input  logic                 words_done,
   input  logic                 last_block,
   input  logic                 drain_done,
   input  logic                 query_done,
   input  logic                 subject_done,
   output blast_pkg::phase_t    phase,
   output logic                 busy,
   output logic                 finished
);
   import blast_pkg::*;

   blast_state_e state;
   blast_state_e next_state;

   always_ff @(posedge clk) begin
      if (reset) begin
         state <= IDLE;
      end else begin
         state <= next_state;
      end
   end

   always_comb begin
      next_state = state;
      case (state)
         IDLE: begin
            // other opcodes are ignored
            if (app_ready && app_code == READ_QUERY) begin
               next_state = LOAD_QUERY;
            end else if (app_ready && app_code == READ_SUBJECT) begin
               next_state = READ_SUBJECT_HEADER;
            end
         end
         LOAD_QUERY: begin
            if (query_done) begin
               next_state = IDLE;
            end
         end
         READ_SUBJECT_HEADER: begin
            if (words_done) begin
               next_state = LOAD_SUBJECT;
            end
         end
         LOAD_SUBJECT: begin
            if (subject_done) begin
               next_state = WRITE_HITS;
            end
         end
         WRITE_HITS: begin
            // back for the next block unless the length is covered
            if (drain_done) begin
               next_state = last_block ? WRITE_HEADER : LOAD_SUBJECT;
            end
         end
         WRITE_HEADER: next_state = IDLE;
         default:      next_state = IDLE;
      endcase
   end

   always_comb begin
      phase.load_query    = state == LOAD_QUERY;
      phase.read_header   = state == READ_SUBJECT_HEADER;
      phase.load_subject  = state == LOAD_SUBJECT;
      phase.write_hits    = state == WRITE_HITS;
      phase.write_header  = state == WRITE_HEADER;
      phase.start_subject = state == IDLE && app_ready && app_code == READ_SUBJECT;
   end

   assign busy     = state != IDLE;
   assign finished = state == WRITE_HEADER;

   // subject length still covered while the header goes out
   a_finish_last_block: assert property (@(posedge clk) disable iff (reset)
      finished |-> last_block);

endmodule

// File: blast_mem_access.sv
`timescale 1ns/100ps

module blast_mem_access (
   input  logic                             clk,
   input  logic                             reset,
   input  blast_pkg::phase_t                phase,
   input  logic [blast_pkg::MEM_DATA_W-1:0] mem_readdata,
   input  logic                             fifo_empty,
   input  blast_pkg::hit_rec_t              fifo_rec,
   input  logic [15:0]                      dropped,
   output blast_pkg::mem_req_t              mem_req,
   output logic [blast_pkg::MEM_DATA_W-1:0] word,
   output logic                             word_valid,
   output logic                             words_done,
   output logic                             last_block,
   output logic                             drain_done,
   output logic                             pop,
   output logic [31:0]                      subject_id
);
   import blast_pkg::*;

   logic [MEM_ADDR_W-1:0] query_addr;
   logic [MEM_ADDR_W-1:0] subj_addr;
   logic [MEM_ADDR_W-1:0] hit_addr;
   logic [2:0]            rd_cnt;
   logic                  idle;
   logic                  block_phase;
   logic                  block_read;
   logic                  last_read;
   logic                  hdr_read;
   logic                  hdr_pending;
   logic                  hit_write;
   logic [31:0]           subject_len;
   logic [31:0]           chars_covered;
   logic [15:0]           hit_cnt;

   assign idle        = ~|{phase.load_query, phase.read_header, phase.load_subject,
                           phase.write_hits, phase.write_header};
   assign block_phase = phase.load_query | phase.load_subject;
   assign block_read  = block_phase && rd_cnt != 3'(BLOCK_WORDS);
   assign last_read   = block_read && rd_cnt == 3'(BLOCK_WORDS - 1);
   // single header read, words_done closes it
   assign hdr_read    = phase.read_header && !words_done;
   assign hit_write   = phase.write_hits && !fifo_empty;
   assign pop         = hit_write;
   assign word        = mem_readdata;
   assign last_block  = chars_covered >= subject_len;

   always_comb begin
      mem_req.read  = block_read | hdr_read;
      mem_req.write = hit_write | phase.write_header;
      if (phase.load_query) begin
         mem_req.addr = query_addr;
      end else if (phase.write_hits) begin
         mem_req.addr = hit_addr;
      end else if (phase.write_header) begin
         mem_req.addr = MEM_HIT_ADDR;
      end else begin
         mem_req.addr = subj_addr;
      end
      mem_req.writedata = phase.write_header ? {subject_id, hit_cnt, dropped} : fifo_rec;
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         rd_cnt        <= '0;
         word_valid    <= 1'b0;
         words_done    <= 1'b0;
         hdr_pending   <= 1'b0;
         drain_done    <= 1'b0;
         query_addr    <= MEM_QUERY_ADDR;
         subj_addr     <= MEM_SUBJECT_ADDR;
         hit_addr      <= MEM_HIT_ADDR + 1'b1;
         chars_covered <= '0;
         hit_cnt       <= '0;
      end else begin
         word_valid  <= mem_req.read;
         hdr_pending <= hdr_read;
         words_done  <= hdr_read | last_read;
         // one cycle late so a push landing on the first drain cycle is seen
         drain_done  <= phase.write_hits && fifo_empty && !drain_done;
         if (!block_phase) begin
            rd_cnt <= '0;
         end else if (block_read) begin
            rd_cnt <= rd_cnt + 1'b1;
         end
         if (idle) begin
            query_addr <= MEM_QUERY_ADDR;
         end else if (block_read && phase.load_query) begin
            query_addr <= query_addr + 1'b1;
         end
         if (phase.start_subject) begin
            subj_addr     <= MEM_SUBJECT_ADDR;
            hit_addr      <= MEM_HIT_ADDR + 1'b1;
            chars_covered <= '0;
            hit_cnt       <= '0;
         end else begin
            if (hdr_read || (block_read && phase.load_subject)) begin
               subj_addr <= subj_addr + 1'b1;
            end
            if (last_read && phase.load_subject) begin
               chars_covered <= chars_covered + 32'(BLOCK_CHARS);
            end
            if (hit_write) begin
               hit_addr <= hit_addr + 1'b1;
               hit_cnt  <= hit_cnt + 1'b1;
            end
         end
      end
   end

   // id high, length in characters low
   always_ff @(posedge clk) begin
      if (hdr_pending) begin
         {subject_id, subject_len} <= mem_readdata;
      end
   end

   a_no_read_write: assert property (@(posedge clk) disable iff (reset)
      !(mem_req.read && mem_req.write));

endmodule

// File: seq_loader.sv
`timescale 1ns/100ps

module seq_loader (
   input  logic                             clk,
   input  logic                             reset,
   input  logic                             enable,
   input  logic [blast_pkg::MEM_DATA_W-1:0] word,
   input  logic                             word_valid,
   output blast_pkg::seq_char_t             char_out,
   output logic                             stream_done
);
   import blast_pkg::*;

   logic [BLOCK_WORDS*MEM_DATA_W-1:0] block;
   logic [$clog2(BLOCK_WORDS+1)-1:0]  word_cnt;
   logic [$clog2(BLOCK_CHARS)-1:0]    char_cnt;
   logic                              streaming;

   // full block present, shift characters out
   assign streaming      = word_cnt == ($bits(word_cnt))'(BLOCK_WORDS);
   assign char_out.valid = streaming;
   assign char_out.code  = block[CHAR_W-1:0];
   assign stream_done    = streaming && char_cnt == ($bits(char_cnt))'(BLOCK_CHARS - 1);

   always_ff @(posedge clk) begin
      if (reset) begin
         word_cnt <= '0;
         char_cnt <= '0;
      end else if (!enable) begin
         word_cnt <= '0;
         char_cnt <= '0;
      end else if (streaming) begin
         char_cnt <= char_cnt + 1'b1;
         if (stream_done) begin
            word_cnt <= '0;
            char_cnt <= '0;
         end
      end else if (word_valid) begin
         word_cnt <= word_cnt + 1'b1;
      end
   end

   // word 0 arrives first and ends up in the low bits
   always_ff @(posedge clk) begin
      if (streaming) begin
         block <= block >> CHAR_W;
      end else if (enable && word_valid) begin
         block <= {word, block[BLOCK_WORDS*MEM_DATA_W-1:MEM_DATA_W]};
      end
   end

endmodule

// File: seed_matcher.sv
`timescale 1ns/100ps

module seed_matcher (
   input  logic                 clk,
   input  logic                 reset,
   input  blast_pkg::seq_char_t query_char,
   input  blast_pkg::seq_char_t subject_char,
   input  logic                 start_subject,
   input  logic [31:0]          subject_id,
   output blast_pkg::hit_rec_t  hit,
   output logic                 push
);
   import blast_pkg::*;

   logic [BLOCK_CHARS*CHAR_W-1:0]  query;
   logic [SEED_LEN*CHAR_W-1:0]     window;
   logic [SEED_LEN*CHAR_W-1:0]     window_next;
   logic [$clog2(SEED_LEN)-1:0]    fill;
   logic                           primed;
   logic [23:0]                    pos;
   logic [7:0]                     match_cnt;
   logic [7:0]                     first_pos;
   logic                           found;

   // newest character at the top, oldest in the low bits
   assign window_next = {subject_char.code, window[SEED_LEN*CHAR_W-1:CHAR_W]};
   assign primed      = fill == ($bits(fill))'(SEED_LEN - 1);

   always_comb begin
      match_cnt = '0;
      first_pos = '0;
      found     = 1'b0;
      for (int j = 0; j <= BLOCK_CHARS - SEED_LEN; j++) begin
         if (query[j*CHAR_W +: SEED_LEN*CHAR_W] == window_next) begin
            if (!found) begin
               first_pos = 8'(j);
            end
            found     = 1'b1;
            match_cnt = match_cnt + 1'b1;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (query_char.valid) begin
         query <= {query_char.code, query[BLOCK_CHARS*CHAR_W-1:CHAR_W]};
      end
      if (subject_char.valid) begin
         window <= window_next;
      end
      hit.subject_id  <= subject_id[23:0];
      hit.subject_pos <= pos - 24'(SEED_LEN - 1);
      hit.query_pos   <= first_pos;
      hit.match_count <= match_cnt;
   end

   // window fill and position carry across subject blocks
   always_ff @(posedge clk) begin
      if (reset) begin
         fill <= '0;
         pos  <= '0;
         push <= 1'b0;
      end else begin
         push <= subject_char.valid && primed && found;
         if (start_subject) begin
            fill <= '0;
            pos  <= '0;
         end else if (subject_char.valid) begin
            pos <= pos + 1'b1;
            if (!primed) begin
               fill <= fill + 1'b1;
            end
         end
      end
   end

endmodule

// File: hit_fifo.sv
`timescale 1ns/100ps

module hit_fifo (
   input  logic                clk,
   input  logic                reset,
   input  logic                clear,
   input  logic                push,
   input  blast_pkg::hit_rec_t wr_rec,
   input  logic                pop,
   output blast_pkg::hit_rec_t rd_rec,
   output logic                empty,
   output logic [15:0]         dropped
);
   import blast_pkg::*;

   hit_rec_t                        mem [FIFO_DEPTH];
   logic [$clog2(FIFO_DEPTH)-1:0]   wr_ptr;
   logic [$clog2(FIFO_DEPTH)-1:0]   rd_ptr;
   logic [$clog2(FIFO_DEPTH):0]     count;
   logic                            full;

   assign full   = count == ($bits(count))'(FIFO_DEPTH);
   assign empty  = count == '0;
   // show-ahead
   assign rd_rec = mem[rd_ptr];

   always_ff @(posedge clk) begin
      if (reset) begin
         wr_ptr  <= '0;
         rd_ptr  <= '0;
         count   <= '0;
         dropped <= '0;
      end else begin
         if (push && !full) begin
            wr_ptr <= wr_ptr + 1'b1;
         end
         if (pop && !empty) begin
            rd_ptr <= rd_ptr + 1'b1;
         end
         count <= count + (push && !full) - (pop && !empty);
         if (clear) begin
            dropped <= '0;
         end else if (push && full) begin
            dropped <= dropped + 1'b1;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (push && !full) begin
         mem[wr_ptr] <= wr_rec;
      end
   end

   a_no_pop_empty: assert property (@(posedge clk) disable iff (reset) pop |-> !empty);

endmodule

// File: blast_top.sv
`timescale 1ns/100ps

module blast_top (
   input  logic                             clk,
   input  logic                             reset,
   input  logic                             app_ready,
   input  blast_pkg::app_code_e             app_code,
   input  logic [blast_pkg::MEM_DATA_W-1:0] mem_readdata,
   output blast_pkg::mem_req_t              mem_req,
   output logic                             busy,
   output logic                             finished
);
   import blast_pkg::*;

   phase_t                phase;
   logic [MEM_DATA_W-1:0] word;
   logic                  word_valid;
   logic                  words_done;
   logic                  last_block;
   logic                  drain_done;
   logic                  query_done;
   logic                  subject_done;
   logic                  pop;
   logic                  push;
   logic                  fifo_empty;
   logic [15:0]           dropped;
   logic [31:0]           subject_id;
   seq_char_t             query_char;
   seq_char_t             subject_char;
   hit_rec_t              hit;
   hit_rec_t              fifo_rec;

   blast_ctrl i_blast_ctrl (
      .clk, .reset, .app_ready, .app_code, .words_done, .last_block, .drain_done,
      .query_done, .subject_done, .phase, .busy, .finished
   );

   blast_mem_access i_blast_mem_access (
      .clk, .reset, .phase, .mem_readdata, .fifo_empty, .fifo_rec, .dropped, .mem_req,
      .word, .word_valid, .words_done, .last_block, .drain_done, .pop, .subject_id
   );

   // both loaders see every word, each takes it only in its own phase
   seq_loader query_loader (
      .clk, .reset, .enable(phase.load_query), .word, .word_valid,
      .char_out(query_char), .stream_done(query_done)
   );

   seq_loader subject_loader (
      .clk, .reset, .enable(phase.load_subject), .word, .word_valid,
      .char_out(subject_char), .stream_done(subject_done)
   );

   seed_matcher i_seed_matcher (
      .clk, .reset, .query_char, .subject_char, .start_subject(phase.start_subject),
      .subject_id, .hit, .push
   );

   hit_fifo i_hit_fifo (
      .clk, .reset, .clear(phase.start_subject), .push, .wr_rec(hit), .pop,
      .rd_rec(fifo_rec), .empty(fifo_empty), .dropped
   );

endmodule

// File: tb_blast.sv
`timescale 1ns/100ps

module tb_blast;
   import blast_pkg::*;

   localparam int         MEM_WORDS  = 2048;
   localparam int         MAX_BLOCKS = 8;
   localparam int         TIMEOUT    = 4000;
   localparam logic [10:0] HDR_IDX   = MEM_HIT_ADDR[10:0];

   logic                  clk;
   logic                  reset;
   logic                  app_ready;
   app_code_e             app_code;
   logic [MEM_DATA_W-1:0] mem_readdata;
   mem_req_t              mem_req;
   logic                  busy;
   logic                  finished;

   logic [MEM_DATA_W-1:0] mem [MEM_WORDS];
   logic [CHAR_W-1:0]     qchar [BLOCK_CHARS];
   hit_rec_t              exp_hits [$];
   logic                  rd_pending = 1'b0;
   logic [MEM_ADDR_W-1:0] rd_addr = '0;
   logic                  mon_on = 1'b0;
   logic                  cmd_seen = 1'b0;
   int                    hit_index = 0;
   int                    write_count = 0;
   int                    finished_count = 0;
   int                    exp_kept = 0;
   int                    exp_dropped = 0;
   int                    value_errors = 0;
   int                    other_errors = 0;

   blast_top i_blast_top (
      .clk, .reset, .app_ready, .app_code, .mem_readdata, .mem_req, .busy, .finished
   );

   initial begin
      clk = 1'b0;
      forever #4 clk = ~clk;
   end

   task automatic report_mismatch(input string name, input logic [63:0] got,
                                  input logic [63:0] exp);
      value_errors++;
      $display("[FAIL] %s: got %h, expected %h", name, got, exp);
   endtask

   task automatic report_problem(input string msg);
      other_errors++;
      $display("ERROR: %s", msg);
   endtask

   // character k of the six-word block at base
   function automatic logic [CHAR_W-1:0] block_char(input int base, input int k);
      logic [BLOCK_WORDS*MEM_DATA_W-1:0] blk;
      for (int i = 0; i < BLOCK_WORDS; i++) begin
         blk[i*MEM_DATA_W +: MEM_DATA_W] = mem[11'(base + i)];
      end
      return blk[k*CHAR_W +: CHAR_W];
   endfunction

   // expected records per block, first FIFO_DEPTH kept, the rest dropped
   task automatic predict_hits(input logic [63:0] hdr);
      logic [CHAR_W-1:0] s [MAX_BLOCKS*BLOCK_CHARS];
      hit_rec_t          rec;
      int                nblk;
      int                kept;
      int                cnt;
      int                first;
      bit                same;
      nblk = int'(({1'b0, hdr[31:0]} + 33'(BLOCK_CHARS - 1)) / 33'(BLOCK_CHARS));
      if (nblk == 0) begin
         nblk = 1;
      end
      if (nblk > MAX_BLOCKS) begin
         report_problem("subject length exceeds the blocks the model can hold");
         nblk = MAX_BLOCKS;
      end
      exp_hits.delete();
      exp_kept    = 0;
      exp_dropped = 0;
      for (int b = 0; b < nblk; b++) begin
         for (int k = 0; k < BLOCK_CHARS; k++) begin
            s[b*BLOCK_CHARS + k] = block_char(int'(MEM_SUBJECT_ADDR) + 1 + b*BLOCK_WORDS, k);
         end
      end
      for (int b = 0; b < nblk; b++) begin
         kept = 0;
         for (int p = b*BLOCK_CHARS; p < (b + 1)*BLOCK_CHARS; p++) begin
            cnt   = 0;
            first = 0;
            // window ends at p and runs on across block boundaries
            if (p >= SEED_LEN - 1) begin
               for (int j = 0; j <= BLOCK_CHARS - SEED_LEN; j++) begin
                  same = 1'b1;
                  for (int i = 0; i < SEED_LEN; i++) begin
                     if (qchar[j + i] != s[p - SEED_LEN + 1 + i]) begin
                        same = 1'b0;
                     end
                  end
                  if (same) begin
                     if (cnt == 0) begin
                        first = j;
                     end
                     cnt++;
                  end
               end
            end
            if (cnt > 0 && kept < FIFO_DEPTH) begin
               rec.subject_id  = hdr[55:32];
               rec.subject_pos = 24'(p - SEED_LEN + 1);
               rec.query_pos   = 8'(first);
               rec.match_count = 8'(cnt);
               exp_hits.push_back(rec);
               kept++;
            end else if (cnt > 0) begin
               exp_dropped++;
            end
         end
         exp_kept += kept;
      end
   endtask

   task automatic check_hit(input logic [MEM_ADDR_W-1:0] addr, input logic [63:0] data);
      logic [MEM_ADDR_W-1:0] exp_addr;
      exp_addr = MEM_HIT_ADDR + 14'(1 + hit_index);
      if (exp_hits.size() == 0) begin
         report_problem($sformatf("write to address %h with no hit record predicted", addr));
      end else begin
         if (addr !== exp_addr) begin
            report_mismatch("mem_req.addr", 64'(addr), 64'(exp_addr));
         end
         if (data !== exp_hits[0]) begin
            report_mismatch("mem_req.writedata", data, exp_hits[0]);
         end
         void'(exp_hits.pop_front());
         hit_index++;
      end
   endtask

   // bus monitor and memory writes, sampled mid-cycle
   always @(negedge clk) begin
      if (mon_on) begin
         if (!cmd_seen) begin
            if (mem_req.read !== 1'b0) begin
               report_mismatch("mem_req.read", 64'(mem_req.read), 64'h0);
            end
            if (mem_req.write !== 1'b0) begin
               report_mismatch("mem_req.write", 64'(mem_req.write), 64'h0);
            end
            if (busy !== 1'b0) begin
               report_mismatch("busy", 64'(busy), 64'h0);
            end
            if (finished !== 1'b0) begin
               report_mismatch("finished", 64'(finished), 64'h0);
            end
         end
         if (finished === 1'b1) begin
            finished_count++;
         end
         if (mem_req.write === 1'b1) begin
            write_count++;
            if (mem_req.addr >= MEM_WORDS) begin
               report_problem($sformatf("write outside the memory at %h", mem_req.addr));
            end else begin
               mem[mem_req.addr[10:0]] = mem_req.writedata;
               if (mem_req.addr != MEM_HIT_ADDR) begin
                  check_hit(mem_req.addr, mem_req.writedata);
               end
            end
         end
         rd_pending = mem_req.read;
         rd_addr    = mem_req.addr;
      end
   end

   // read data in the cycle after the request
   always @(posedge clk) begin
      #1;
      if (rd_pending) begin
         mem_readdata = (rd_addr < MEM_WORDS) ? mem[rd_addr[10:0]] : '0;
      end
   end

   task automatic wait_idle();
      int cycles;
      cycles = 0;
      while (busy === 1'b1 && cycles < TIMEOUT) begin
         @(posedge clk);
         #1;
         cycles++;
      end
      if (busy !== 1'b0) begin
         report_problem($sformatf("timeout, busy still high after %0d cycles", TIMEOUT));
      end
   endtask

   task automatic run_command(input logic [7:0] code);
      int          writes_before;
      logic [63:0] hdr;
      logic [63:0] exp_header;
      writes_before = write_count;
      hdr = mem[MEM_SUBJECT_ADDR[10:0]];
      if (code == READ_QUERY) begin
         for (int k = 0; k < BLOCK_CHARS; k++) begin
            qchar[k] = block_char(int'(MEM_QUERY_ADDR), k);
         end
      end else if (code == READ_SUBJECT) begin
         predict_hits(hdr);
         hit_index      = 0;
         finished_count = 0;
      end
      cmd_seen = 1'b1;
      @(posedge clk);
      #1;
      app_ready = 1'b1;
      app_code  = app_code_e'(code);
      @(posedge clk);
      #1;
      app_ready = 1'b0;
      if (code == READ_QUERY || code == READ_SUBJECT) begin
         wait_idle();
      end else begin
         // unknown opcode leaves the FSM idle
         for (int c = 0; c < 8; c++) begin
            if (busy !== 1'b0) begin
               report_mismatch("busy", 64'(busy), 64'h0);
            end
            @(posedge clk);
            #1;
         end
         if (write_count != writes_before) begin
            report_problem("memory was written after an unknown command");
         end
      end
      if (code == READ_SUBJECT) begin
         if (exp_hits.size() != 0) begin
            report_problem($sformatf("%0d predicted hit records never written",
                                     exp_hits.size()));
         end
         if (finished_count != 1) begin
            report_mismatch("finished pulse count", 64'(finished_count), 64'h1);
         end
         exp_header = {hdr[63:32], 16'(exp_kept), 16'(exp_dropped)};
         if (mem[HDR_IDX] !== exp_header) begin
            report_mismatch("header word", mem[HDR_IDX], exp_header);
         end
      end
   endtask

   initial begin
      int               fd;
      int               n;
      logic [63:0]      kind;
      logic [63:0]      a;
      logic [63:0]      d;
      logic [63:0]      e_hits;
      logic [63:0]      e_drop;
      logic [8*128-1:0] rest;
      reset        = 1'b1;
      app_ready    = 1'b0;
      app_code     = app_code_e'(8'h00);
      mem_readdata = '0;
      for (int i = 0; i < MEM_WORDS; i++) begin
         mem[i] = '0;
      end
      @(posedge clk);
      mon_on = 1'b1;
      repeat (15) @(posedge clk);
      #1;
      reset = 1'b0;
      repeat (4) @(posedge clk);
      fd = $fopen("blast_stimulus.txt", "r");
      if (fd == 0) begin
         report_problem("cannot open blast_stimulus.txt");
      end else begin
         n = $fscanf(fd, "%s", kind);
         while (n == 1) begin
            if (kind == "#") begin
               n = $fgets(rest, fd);
            end else if (kind == "M") begin
               n = $fscanf(fd, "%h %h", a, d);
               mem[a[10:0]] = d;
            end else if (kind == "C") begin
               n = $fscanf(fd, "%h", a);
               run_command(a[7:0]);
            end else if (kind == "E") begin
               n = $fscanf(fd, "%h %h %h", a, e_hits, e_drop);
               if (mem[HDR_IDX][63:32] !== a[31:0]) begin
                  report_mismatch("header subject_id", 64'(mem[HDR_IDX][63:32]), a);
               end
               if (mem[HDR_IDX][31:16] !== e_hits[15:0]) begin
                  report_mismatch("header hit count", 64'(mem[HDR_IDX][31:16]), e_hits);
               end
               if (mem[HDR_IDX][15:0] !== e_drop[15:0]) begin
                  report_mismatch("header dropped", 64'(mem[HDR_IDX][15:0]), e_drop);
               end
            end else begin
               report_problem($sformatf("unknown stimulus line kind %0s", kind));
            end
            n = $fscanf(fd, "%s", kind);
         end
         $fclose(fd);
      end
      $display("value mismatches: %0d, other failures: %0d", value_errors, other_errors);
      if (value_errors + other_errors == 0) begin
         $display("Finished with no errors");
      end else begin
         $display("Finished with errors");
      end
      $finish;
   end

endmodule

// File: sim.f
blast_pkg.sv
blast_ctrl.sv
blast_mem_access.sv
seq_loader.sv
seed_matcher.sv
hit_fifo.sv
blast_top.sv
tb_blast.sv

// File: Makefile
TOP = tb_blast

.PHONY: all lint clean

all: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) > sim.log 2>&1; cat sim.log
	@if grep -q "Finished with errors" sim.log; then echo "simulation failed"; exit 1; fi
	@grep -q "Finished with no errors" sim.log || (echo "simulation did not complete"; exit 1)

obj_dir/V$(TOP): sim.f $(wildcard *.sv)
	verilator --binary --timing --assert -Wno-fatal -f sim.f --top-module $(TOP)

lint:
	verilator --lint-only -Wall --timing -f sim.f --top-module $(TOP)

clean:
	rm -rf obj_dir sim.log

// File: blast_stimulus.txt
# one step per line, numbers in hex: M addr data preloads a word, C code strobes a command,
# E id hits dropped is the expected result header after the last subject command
# query of 7s with seed 1 2 3 4 at position 0
M 0 FFFFFFFFFFFFF8D1
M 1 FFFFFFFFFFFFFFFF
M 2 FFFFFFFFFFFFFFFF
M 3 FFFFFFFFFFFFFFFF
M 4 FFFFFFFFFFFFFFFF
M 5 FFFFFFFFFFFFFFFF
# two-block subject of 0s, seeds at 5 and across the boundary at 126
M C 00ABCDEF00000100
M D 0000000004688000
M 12 4400000000000000
M 13 0000000000000023
C AA
C BB
E ABCDEF 2 0
# query and subject all 0, every window overflows the FIFO
M 0 0000000000000000
M 1 0000000000000000
M 2 0000000000000000
M 3 0000000000000000
M 4 0000000000000000
M 5 0000000000000000
M D 0000000000000000
M 12 0000000000000000
M 13 0000000000000000
M C 0000004200000100
C AA
C BB
E 42 20 DD
C 55
